/* Bender.yml */
package:
  name: adc_stats

sources:
  - files:
      - src/adcStatsPkg.sv
      - src/sampleBusIf.sv
      - src/sampleCapture.sv
      - src/statsEngine.sv
      - src/hostReadout.sv
      - src/bufferArbiter.sv
      - src/sampleRam.sv
      - src/adcStatsTop.sv
  - target: test
    files:
      - dv/adcStats_assert.sv
      - dv/adcStatsTb.sv

/* dv/adcStatsTb.sv */
`default_nettype none

module adcStatsTb import adcStatsPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAND_WINDOWS = 4;
    localparam int SLOT         = 4;
    // Host read on every other slot of the random windows
    localparam int HOST_READS   = RAND_WINDOWS * SAMPLES / 2;
    localparam int MARGIN       = 500;

    logic              clk;
    logic              rst;
    logic              sampleValid;
    sample_t           sampleData;
    logic              hostRdReq;
    logic [ADDR_W-1:0] hostRdAddr;
    logic              hostRdValid;
    sample_t           hostRdData;
    logic              statsValid;
    sample_t           average;
    sample_t           minimum;
    sample_t           maximum;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and scoreboard
    ////////////////////////////////////////////////////////////////////////////

    // Copy of every sample written, same bank layout as the RAM
    sample_t modelMem [RAM_DEPTH];
    logic    modelBank;
    int      modelIdx;
    sample_t windowBuf [SAMPLES];

    // Expected results, oldest first
    string   statsName [$];
    sample_t expAvg [$];
    sample_t expMin [$];
    sample_t expMax [$];
    sample_t expHost [$];
    int      expHostAddr [$];

    // Ramp cases from the file
    string   caseName [$];
    int      caseStart [$];
    int      caseStep [$];
    int      caseAvg [$];
    int      caseMin [$];
    int      caseMax [$];

    int      errors;
    int      checks;
    int      cycles;
    int      cycleLimit;
    int      statsSeen;
    int      windowsSent;
    integer  seed;

    adcStatsTop DUT (
        .clk         (clk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .hostRdReq   (hostRdReq),
        .hostRdAddr  (hostRdAddr),
        .hostRdValid (hostRdValid),
        .hostRdData  (hostRdData),
        .statsValid  (statsValid),
        .average     (average),
        .minimum     (minimum),
        .maximum     (maximum)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic loadCases();
        int    fd;
        int    n;
        string line;
        string name;
        int    start;
        int    step;
        int    avg;
        int    mn;
        int    mx;
        fd = $fopen("dv/stats_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the case file dv/stats_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // Skip comments and blank lines
                if (n > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %d %d %d %d %d", name, start, step,
                                avg, mn, mx) == 6) begin
                        caseName.push_back(name);
                        caseStart.push_back(start);
                        caseStep.push_back(step);
                        caseAvg.push_back(avg);
                        caseMin.push_back(mn);
                        caseMax.push_back(mx);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Floor average and extremes of windowBuf
    function automatic void windowStats(output sample_t avg, output sample_t mn,
                                        output sample_t mx);
        int sum;
        int i;
        sum = 0;
        mn  = '1;
        mx  = '0;
        for (i = 0; i < SAMPLES; i++) begin
            sum += windowBuf[i];
            if (windowBuf[i] < mn) mn = windowBuf[i];
            if (windowBuf[i] > mx) mx = windowBuf[i];
        end
        avg = sample_t'(sum / SAMPLES);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // One sample slot, optionally with a host read in the same cycle
    task automatic sendSlot(input sample_t value, input logic doRead,
                            input logic [ADDR_W-1:0] addr);
        @(posedge clk);
        sampleValid <= 1'b1;
        sampleData  <= value;
        modelMem[int'(modelBank) * SAMPLES + modelIdx] = value;
        modelIdx++;
        if (modelIdx == SAMPLES) begin
            modelIdx  = 0;
            modelBank = ~modelBank;
        end
        // Capture wins the tie, so the read sees this write
        if (doRead) begin
            hostRdReq  <= 1'b1;
            hostRdAddr <= addr;
            expHostAddr.push_back(addr);
            if (addr < RAM_DEPTH) begin
                expHost.push_back(modelMem[addr]);
            end else begin
                expHost.push_back('0);
            end
        end
        @(posedge clk);
        sampleValid <= 1'b0;
        hostRdReq   <= 1'b0;
        repeat (SLOT - 2) @(posedge clk);
    endtask

    task automatic sendWindow(input string name, input sample_t avgExp,
                              input sample_t minExp, input sample_t maxExp,
                              input logic withHost);
        int                i;
        logic [ADDR_W-1:0] addr;
        for (i = 0; i < SAMPLES; i++) begin
            // Includes addresses past the RAM
            addr = ADDR_W'($unsigned($random(seed)) % (RAM_DEPTH + 32));
            sendSlot(windowBuf[i], withHost && (i % 2 == 0), addr);
        end
        statsName.push_back(name);
        expAvg.push_back(avgExp);
        expMin.push_back(minExp);
        expMax.push_back(maxExp);
        windowsSent++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && statsValid) begin
            statsSeen++;
            if (statsName.size() == 0) begin
                errors++;
                $display("statsValid pulsed with no window outstanding");
            end else begin
                checkValue({statsName[0], " average"}, expAvg[0], average);
                checkValue({statsName[0], " minimum"}, expMin[0], minimum);
                checkValue({statsName[0], " maximum"}, expMax[0], maximum);
                void'(statsName.pop_front());
                void'(expAvg.pop_front());
                void'(expMin.pop_front());
                void'(expMax.pop_front());
            end
        end
        if (!rst && hostRdValid) begin
            if (expHost.size() == 0) begin
                errors++;
                $display("hostRdValid pulsed with no host read outstanding");
            end else begin
                checkValue($sformatf("host read %0d", expHostAddr[0]), expHost[0],
                           hostRdData);
                void'(expHost.pop_front());
                void'(expHostAddr.pop_front());
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Run stopped after %0d cycles before the tests finished", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int      c;
        int      i;
        int      waitCount;
        sample_t a;
        sample_t mn;
        sample_t mx;
        rst         = 1'b1;
        sampleValid = 1'b0;
        sampleData  = '0;
        hostRdReq   = 1'b0;
        hostRdAddr  = '0;
        modelBank   = 1'b0;
        modelIdx    = 0;
        seed        = 32'h5bfc;
        loadCases();
        cycleLimit = (caseName.size() + RAND_WINDOWS) * SAMPLES * SLOT
                   + HOST_READS * SLOT + MARGIN;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Quiet outputs before the first sample
        repeat (8) begin
            @(posedge clk);
            checkValue("reset statsValid", 0, statsValid);
            checkValue("reset hostRdValid", 0, hostRdValid);
            checkValue("reset average", 0, average);
            checkValue("reset minimum", 0, minimum);
            checkValue("reset maximum", 0, maximum);
        end

        // Ramp windows, back to back
        for (c = 0; c < caseName.size(); c++) begin
            for (i = 0; i < SAMPLES; i++) begin
                windowBuf[i] = sample_t'((caseStart[c] + i * caseStep[c]) % (2 ** SAMPLE_W));
            end
            sendWindow(caseName[c], caseAvg[c], caseMin[c], caseMax[c], 1'b0);
        end

        // Random windows with host reads running alongside
        for (c = 0; c < RAND_WINDOWS; c++) begin
            for (i = 0; i < SAMPLES; i++) begin
                windowBuf[i] = sample_t'($random(seed));
            end
            windowStats(a, mn, mx);
            sendWindow($sformatf("random%0d", c), a, mn, mx, 1'b1);
        end

        // Drain the last results
        waitCount = 0;
        while ((statsName.size() != 0 || expHost.size() != 0) && waitCount < 200) begin
            @(posedge clk);
            waitCount++;
        end
        repeat (20) @(posedge clk);
        if (statsName.size() != 0) begin
            errors++;
            $display("statsValid never arrived for %0d window(s), first %s",
                     statsName.size(), statsName[0]);
        end
        if (expHost.size() != 0) begin
            errors++;
            $display("hostRdValid never arrived for %0d host read(s)", expHost.size());
        end
        checkValue("statsValid count", windowsSent, statsSeen);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/adcStats_assert.sv */
`default_nettype none

module adcStatsAssert import adcStatsPkg::*; (
    input logic               clk,
    input logic               rst,
    input logic [NUM_REQ-1:0] reqVec,
    input logic [NUM_REQ-1:0] gntVec,
    input logic               statsValid,
    input sample_t            average,
    input sample_t            minimum,
    input sample_t            maximum
);

    timeunit 1ns;
    timeprecision 1ps;

    // Single RAM owner per cycle
    oneGrant: assert property (@(posedge clk) disable iff (rst) $onehot0(gntVec))
        else $error("more than one RAM grant in a cycle");

    // Grant only to an active requester
    grantHasReq: assert property (@(posedge clk) disable iff (rst) (gntVec & ~reqVec) == '0)
        else $error("grant given to a requester that is not requesting");

    statsPulse: assert property (@(posedge clk) disable iff (rst) statsValid |=> !statsValid)
        else $error("statsValid held longer than one cycle");

    // Average lies between the extremes
    statsOrder: assert property (@(posedge clk) disable iff (rst)
        statsValid |-> (minimum <= average) && (average <= maximum))
        else $error("result has minimum, average and maximum out of order");

endmodule

bind adcStatsTop adcStatsAssert uAssert (
    .clk        (clk),
    .rst        (rst),
    // Request and grant as seen on each requester's bus
    .reqVec     ({statsBus.req, hostBus.req, captureBus.req}),
    .gntVec     ({statsBus.gnt, hostBus.gnt, captureBus.gnt}),
    .statsValid (statsValid),
    .average    (average),
    .minimum    (minimum),
    .maximum    (maximum)
);

`default_nettype wire

/* dv/stats_cases.txt */
# name start step average minimum maximum, all decimal
# sample i = (start + i * step) mod 4096 for i = 0..79
constant      1000     0  1000  1000  1000
fullScale     4095     0  4095  4095  4095
allZero          0     0     0     0     0
ascending        0     1    39     0    79
descending     100  4095    60    21   100
wrapStep10    4050    10   605     4  4090
wrapStep64       0    64  1708     0  4032
midScale      2048     1  2087  2048  2127

/* flist.f */
src/adcStatsPkg.sv
src/sampleBusIf.sv
src/sampleCapture.sv
src/statsEngine.sv
src/hostReadout.sv
src/bufferArbiter.sv
src/sampleRam.sv
src/adcStatsTop.sv
dv/adcStats_assert.sv
dv/adcStatsTb.sv

/* src/adcStatsPkg.sv */
`default_nettype none

package adcStatsPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample format
    ////////////////////////////////////////////////////////////////////////////

    // Raw ADC word, unsigned
    localparam int SAMPLE_W = 12;
    typedef logic [SAMPLE_W-1:0] sample_t;

    ////////////////////////////////////////////////////////////////////////////
    // Window and RAM geometry
    ////////////////////////////////////////////////////////////////////////////

    // One window per bank
    localparam int SAMPLES   = 80;
    localparam int BANKS     = 2;
    localparam int RAM_DEPTH = SAMPLES * BANKS;
    localparam int ADDR_W    = $clog2(RAM_DEPTH);
    // Index of a sample inside its window
    localparam int IDX_W     = $clog2(SAMPLES);
    // Room for a full window at full scale
    localparam int SUM_W     = SAMPLE_W + $clog2(SAMPLES);

    // Arbiter ports, lower index wins
    localparam int REQ_CAPTURE = 0;
    localparam int REQ_HOST    = 1;
    localparam int REQ_STATS   = 2;
    localparam int NUM_REQ     = 3;

    // RAM word of sample idx in the given bank
    function automatic logic [ADDR_W-1:0] sampleAddr(input logic bank,
                                                     input logic [IDX_W-1:0] idx);
        logic [ADDR_W-1:0] base;
        base = bank ? ADDR_W'(SAMPLES) : '0;
        return base + ADDR_W'(idx);
    endfunction

endpackage

`default_nettype wire

/* src/adcStatsTop.sv */
`default_nettype none

module adcStatsTop import adcStatsPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               sampleValid,
    input  sample_t            sampleData,
    input  logic               hostRdReq,
    input  logic [ADDR_W-1:0]  hostRdAddr,
    output logic               hostRdValid,
    output sample_t            hostRdData,
    output logic               statsValid,
    output sample_t            average,
    output sample_t            minimum,
    output sample_t            maximum
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal buses
    ////////////////////////////////////////////////////////////////////////////

    sampleBusIf captureBus ();
    sampleBusIf hostBus ();
    sampleBusIf statsBus ();

    // Window handoff from capture to statistics
    logic              windowDone;
    logic              doneBank;

    // RAM port
    logic              ramEn;
    logic              ramWe;
    logic [ADDR_W-1:0] ramAddr;
    sample_t           ramWdata;
    sample_t           ramRdata;

    ////////////////////////////////////////////////////////////////////////////
    // Requesters
    ////////////////////////////////////////////////////////////////////////////

    sampleCapture uCapture (
        .clk         (clk),
        .rst         (rst),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .bus         (captureBus.requester),
        .windowDone  (windowDone),
        .doneBank    (doneBank)
    );

    hostReadout uHost (
        .clk         (clk),
        .rst         (rst),
        .hostRdReq   (hostRdReq),
        .hostRdAddr  (hostRdAddr),
        .bus         (hostBus.requester),
        .hostRdValid (hostRdValid),
        .hostRdData  (hostRdData)
    );

    statsEngine uStats (
        .clk        (clk),
        .rst        (rst),
        .windowDone (windowDone),
        .doneBank   (doneBank),
        .bus        (statsBus.requester),
        .statsValid (statsValid),
        .average    (average),
        .minimum    (minimum),
        .maximum    (maximum)
    );

    // Shared RAM behind the arbiter
    bufferArbiter uArbiter (
        .clk      (clk),
        .rst      (rst),
        .capture  (captureBus.arbiter),
        .host     (hostBus.arbiter),
        .stats    (statsBus.arbiter),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    sampleRam uRam (
        .clk   (clk),
        .en    (ramEn),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

`default_nettype wire

/* src/bufferArbiter.sv */
`default_nettype none

module bufferArbiter import adcStatsPkg::*; (
    input  logic               clk,
    input  logic               rst,
    sampleBusIf.arbiter        capture,
    sampleBusIf.arbiter        host,
    sampleBusIf.arbiter        stats,
    output logic               ramEn,
    output logic               ramWe,
    output logic [ADDR_W-1:0]  ramAddr,
    output sample_t            ramWdata,
    input  sample_t            ramRdata
);

    logic [NUM_REQ-1:0] reqVec;
    logic [NUM_REQ-1:0] gntVec;
    // One-hot owner of the read now in the RAM
    logic [NUM_REQ-1:0] rdOwner;

    always_comb begin
        reqVec              = '0;
        reqVec[REQ_CAPTURE] = capture.req;
        reqVec[REQ_HOST]    = host.req;
        reqVec[REQ_STATS]   = stats.req;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fixed priority grant and RAM mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        gntVec   = '0;
        ramWe    = 1'b0;
        ramAddr  = '0;
        ramWdata = '0;
        if (reqVec[REQ_CAPTURE]) begin
            gntVec[REQ_CAPTURE] = 1'b1;
            ramWe               = capture.we;
            ramAddr             = capture.addr;
            ramWdata            = capture.wdata;
        end else if (reqVec[REQ_HOST]) begin
            gntVec[REQ_HOST] = 1'b1;
            ramWe            = host.we;
            ramAddr          = host.addr;
            ramWdata         = host.wdata;
        end else if (reqVec[REQ_STATS]) begin
            gntVec[REQ_STATS] = 1'b1;
            ramWe             = stats.we;
            ramAddr           = stats.addr;
            ramWdata          = stats.wdata;
        end
    end

    assign ramEn = |gntVec;

    assign capture.gnt = gntVec[REQ_CAPTURE];
    assign host.gnt    = gntVec[REQ_HOST];
    assign stats.gnt   = gntVec[REQ_STATS];

    ////////////////////////////////////////////////////////////////////////////
    // Read return steering
    ////////////////////////////////////////////////////////////////////////////

    // Writes return nothing
    always_ff @(posedge clk) begin
        if (rst) begin
            rdOwner <= '0;
        end else begin
            rdOwner <= ramWe ? '0 : gntVec;
        end
    end

    assign capture.rvalid = rdOwner[REQ_CAPTURE];
    assign host.rvalid    = rdOwner[REQ_HOST];
    assign stats.rvalid   = rdOwner[REQ_STATS];

    // Data only on the owner's bus
    assign capture.rdata = rdOwner[REQ_CAPTURE] ? ramRdata : '0;
    assign host.rdata    = rdOwner[REQ_HOST] ? ramRdata : '0;
    assign stats.rdata   = rdOwner[REQ_STATS] ? ramRdata : '0;

endmodule

`default_nettype wire

/* src/hostReadout.sv */
`default_nettype none

module hostReadout import adcStatsPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               hostRdReq,
    input  logic [ADDR_W-1:0]  hostRdAddr,
    sampleBusIf.requester      bus,
    output logic               hostRdValid,
    output sample_t            hostRdData
);

    logic [ADDR_W-1:0] addrReg;
    logic              pending;
    // Out of range path, same two-cycle latency as a RAM read
    logic              zeroPending;
    logic              zeroValid;
    logic              inRange;

    assign inRange = (hostRdAddr < ADDR_W'(RAM_DEPTH));

    assign bus.req   = pending;
    assign bus.we    = 1'b0;
    assign bus.addr  = addrReg;
    assign bus.wdata = '0;

    // RAM word or zero for a bad address
    assign hostRdValid = bus.rvalid | zeroValid;
    assign hostRdData  = bus.rvalid ? bus.rdata : '0;

    always_ff @(posedge clk) begin
        if (hostRdReq) begin
            addrReg <= hostRdAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending     <= 1'b0;
            zeroPending <= 1'b0;
            zeroValid   <= 1'b0;
        end else begin
            zeroPending <= hostRdReq & ~inRange;
            zeroValid   <= zeroPending;
            if (hostRdReq && inRange) begin
                pending <= 1'b1;
            end else if (bus.gnt) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/sampleBusIf.sv */
`default_nettype none

// One requester's path into the shared sample RAM
interface sampleBusIf import adcStatsPkg::*; ();

    // Requester side, held until gnt
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    sample_t           wdata;

    // Arbiter side
    logic              gnt;
    sample_t           rdata;
    // One cycle after a granted read
    logic              rvalid;

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

`default_nettype wire

/* src/sampleCapture.sv */
`default_nettype none

module sampleCapture import adcStatsPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               sampleValid,
    input  sample_t            sampleData,
    sampleBusIf.requester      bus,
    output logic               windowDone,
    output logic               doneBank
);

    // Write position
    logic [IDX_W-1:0] idx;
    logic             bank;

    // Sample waiting for its write slot
    logic             pending;
    sample_t          holdData;

    // Write request, capture never reads
    assign bus.req   = pending;
    assign bus.we    = 1'b1;
    assign bus.addr  = sampleAddr(bank, idx);
    assign bus.wdata = holdData;

    // Hold register, reloaded on every strobe
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            holdData <= sampleData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending    <= 1'b0;
            idx        <= '0;
            bank       <= 1'b0;
            windowDone <= 1'b0;
            doneBank   <= 1'b0;
        end else begin
            windowDone <= 1'b0;
            // New strobe keeps the request up
            if (sampleValid) begin
                pending <= 1'b1;
            end else if (bus.gnt) begin
                pending <= 1'b0;
            end
            // Advance on each completed write
            if (bus.gnt) begin
                if (idx == IDX_W'(SAMPLES - 1)) begin
                    // Window full, hand the bank over
                    idx        <= '0;
                    bank       <= ~bank;
                    windowDone <= 1'b1;
                    doneBank   <= bank;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/sampleRam.sv */
`default_nettype none

module sampleRam import adcStatsPkg::*; (
    input  logic               clk,
    input  logic               en,
    input  logic               we,
    input  logic [ADDR_W-1:0]  addr,
    input  sample_t            wdata,
    output sample_t            rdata
);

    // Bank 0 in the lower window, bank 1 above it
    sample_t mem [RAM_DEPTH];

    // Single port, registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                // Output holds during a write
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

/* src/statsEngine.sv */
`default_nettype none

module statsEngine import adcStatsPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               windowDone,
    input  logic               doneBank,
    sampleBusIf.requester      bus,
    output logic               statsValid,
    output sample_t            average,
    output sample_t            minimum,
    output sample_t            maximum
);

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        FINISH
    } statsState_t;

    statsState_t      state;
    // Reads granted so far
    logic [IDX_W-1:0] readIdx;
    // Bank under evaluation
    logic             bankSel;

    // Read-only requester
    assign bus.req   = (state == ISSUE);
    assign bus.we    = 1'b0;
    assign bus.addr  = sampleAddr(bankSel, readIdx);
    assign bus.wdata = '0;

    ////////////////////////////////////////////////////////////////////////////
    // Running statistics
    ////////////////////////////////////////////////////////////////////////////

    logic [SUM_W-1:0] runSum;
    sample_t          runMin;
    sample_t          runMax;

    // Running values with the returning word folded in
    logic [SUM_W-1:0] foldSum;
    sample_t          foldMin;
    sample_t          foldMax;
    logic [SUM_W-1:0] quotient;

    assign foldSum  = runSum + SUM_W'(bus.rdata);
    assign foldMin  = (bus.rdata < runMin) ? bus.rdata : runMin;
    assign foldMax  = (bus.rdata > runMax) ? bus.rdata : runMax;
    // Floor average, always fits a sample
    assign quotient = foldSum / SUM_W'(SAMPLES);

    // Accumulators start fresh on each window
    always_ff @(posedge clk) begin
        if (state == IDLE && windowDone) begin
            runSum  <= '0;
            runMin  <= '1;
            runMax  <= '0;
            bankSel <= doneBank;
        end else if (state == ISSUE && bus.rvalid) begin
            runSum <= foldSum;
            runMin <= foldMin;
            runMax <= foldMax;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            readIdx    <= '0;
            statsValid <= 1'b0;
            average    <= '0;
            minimum    <= '0;
            maximum    <= '0;
        end else begin
            statsValid <= 1'b0;
            case (state)
                IDLE: begin
                    readIdx <= '0;
                    if (windowDone) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    // Lost grant just retries the same word
                    if (bus.gnt) begin
                        readIdx <= readIdx + 1'b1;
                        if (readIdx == IDX_W'(SAMPLES - 1)) begin
                            state <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    // Last word returns here
                    average    <= quotient[SAMPLE_W-1:0];
                    minimum    <= foldMin;
                    maximum    <= foldMax;
                    statsValid <= 1'b1;
                    state      <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
